//--- rtl/hit_monitor_settings.svh
`ifndef HIT_MONITOR_SETTINGS_SVH
`define HIT_MONITOR_SETTINGS_SVH

// number of monitored caches and the shape of each tag store.
`define HM_CHANNELS 4
`define HM_SETS 16
`define HM_INDEX_BITS 4
`define HM_TAG_BITS 8

// window of samples per channel; the group count must stay even.
`define HM_WINDOW_LEN 100
`define HM_GROUP_LEN 10
`define HM_COUNT_BITS 7
`define HM_GROUP_BITS 4

`endif

//--- rtl/hit_monitor_pkg.sv
`include "hit_monitor_settings.svh"

package hit_monitor_pkg;

	// access address is tag above index.
	typedef logic [`HM_TAG_BITS+`HM_INDEX_BITS-1:0] access_addr_t;
	typedef logic [`HM_INDEX_BITS-1:0] set_index_t;
	typedef logic [`HM_TAG_BITS-1:0] cache_tag_t;
	typedef logic [$clog2(`HM_CHANNELS)-1:0] channel_id_t;

	typedef logic [`HM_GROUP_BITS-1:0] group_sum_t;
	typedef logic [`HM_COUNT_BITS-2:0] half_sum_t;	// up to half the window.
	typedef logic [`HM_COUNT_BITS-1:0] hit_count_t;

	typedef enum logic {
		RD_IDLE,
		RD_ACK
	} reader_state_t;

endpackage

//--- rtl/access_tag_probe.sv
`timescale 1ns/1ns
`include "hit_monitor_settings.svh"

module access_tag_probe
	import hit_monitor_pkg::*;
(
	input logic iCLOCK,
	input logic inRESET,
	input logic access_valid,
	input channel_id_t access_channel,
	input access_addr_t access_addr,
	input logic flush,
	output logic [`HM_CHANNELS-1:0] sample_valid,
	output logic [`HM_CHANNELS-1:0] sample_hit
);

	set_index_t access_index;
	cache_tag_t access_tag;

	// one direct-mapped tag store per channel.
	logic [`HM_SETS-1:0] tag_valid [`HM_CHANNELS];
	cache_tag_t tag_store [`HM_CHANNELS][`HM_SETS];

	logic lookup_hit;
	logic fill;

	assign access_index = access_addr[`HM_INDEX_BITS-1:0];
	assign access_tag = access_addr[`HM_INDEX_BITS +: `HM_TAG_BITS];

	// a flush in the same cycle wins, so the access sees an empty store.
	assign lookup_hit = !flush
		&& tag_valid[access_channel][access_index]
		&& (tag_store[access_channel][access_index] == access_tag);

	// misses allocate; nothing is filled during a flush.
	assign fill = access_valid && !flush && !lookup_hit;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			for (int ch = 0; ch < `HM_CHANNELS; ch++) begin
				tag_valid[ch] <= '0;
			end
		end
		else if (flush) begin
			for (int ch = 0; ch < `HM_CHANNELS; ch++) begin
				tag_valid[ch] <= '0;
			end
		end
		else if (fill) begin
			tag_valid[access_channel][access_index] <= 1'b1;
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (fill) begin
			tag_store[access_channel][access_index] <= access_tag;
		end
	end

	// one sample per access, steered to its channel.
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			sample_valid <= '0;
			sample_hit <= '0;
		end
		else begin
			sample_valid <= '0;
			sample_hit <= '0;
			if (access_valid) begin
				sample_valid[access_channel] <= 1'b1;
				sample_hit[access_channel] <= lookup_hit;
			end
		end
	end

endmodule

//--- rtl/hit_window_counter.sv
`timescale 1ns/1ns
`include "hit_monitor_settings.svh"

module hit_window_counter
	import hit_monitor_pkg::*;
(
	input logic iCLOCK,
	input logic inRESET,
	input logic sample_valid,
	input logic sample_hit,
	output hit_count_t count
);

	localparam int GROUPS = `HM_WINDOW_LEN / `HM_GROUP_LEN;
	localparam int HALF_GROUPS = GROUPS / 2;

	logic [`HM_WINDOW_LEN-1:0] history;	// newest sample in bit 0.

	group_sum_t group_next [GROUPS];
	group_sum_t group_sum [GROUPS];
	half_sum_t half_next [2];
	half_sum_t half_sum [2];
	hit_count_t total;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			history <= '0;	// empty window reads as all misses.
		end
		else if (sample_valid) begin
			history <= {history[`HM_WINDOW_LEN-2:0], sample_hit};
		end
	end

	// stage 1 inputs, popcount of each group.
	always_comb begin
		for (int g = 0; g < GROUPS; g++) begin
			group_next[g] = '0;
			for (int b = 0; b < `HM_GROUP_LEN; b++) begin
				group_next[g] = group_next[g] + group_sum_t'(history[g*`HM_GROUP_LEN + b]);
			end
		end
	end

	// stage 2 inputs, lower and upper half of the groups.
	always_comb begin
		for (int h = 0; h < 2; h++) begin
			half_next[h] = '0;
			for (int g = 0; g < HALF_GROUPS; g++) begin
				half_next[h] = half_next[h] + half_sum_t'(group_sum[h*HALF_GROUPS + g]);
			end
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			for (int g = 0; g < GROUPS; g++) begin
				group_sum[g] <= '0;
			end
			half_sum[0] <= '0;
			half_sum[1] <= '0;
			total <= '0;
		end
		else begin
			for (int g = 0; g < GROUPS; g++) begin
				group_sum[g] <= group_next[g];
			end
			half_sum[0] <= half_next[0];
			half_sum[1] <= half_next[1];
			total <= hit_count_t'(half_sum[0]) + hit_count_t'(half_sum[1]);
		end
	end

	assign count = total;

endmodule

//--- rtl/hit_count_reader.sv
`timescale 1ns/1ns
`include "hit_monitor_settings.svh"

module hit_count_reader
	import hit_monitor_pkg::*;
(
	input logic iCLOCK,
	input logic inRESET,
	input logic rd_req,
	input channel_id_t rd_sel,
	input hit_count_t counts [`HM_CHANNELS],
	output logic rd_ack,
	output hit_count_t rd_data
);

	reader_state_t state;
	reader_state_t state_next;
	logic capture;

	// new request seen while idle.
	assign capture = (state == RD_IDLE) && rd_req;

	always_comb begin
		state_next = state;
		case (state)
			RD_IDLE: begin
				if (rd_req) begin
					state_next = RD_ACK;
				end
			end
			RD_ACK: begin
				if (!rd_req) begin
					state_next = RD_IDLE;	// host dropped req, close the handshake.
				end
			end
			default: begin
				state_next = RD_IDLE;
			end
		endcase
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= RD_IDLE;
		end
		else begin
			state <= state_next;
		end
	end

	// data is taken once per request and held through the ack phase.
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			rd_data <= '0;
		end
		else if (capture) begin
			rd_data <= counts[rd_sel];
		end
	end

	assign rd_ack = (state == RD_ACK);

endmodule

//--- rtl/hit_monitor_top.sv
`timescale 1ns/1ns
`include "hit_monitor_settings.svh"

module hit_monitor_top
	import hit_monitor_pkg::*;
(
	input logic iCLOCK,
	input logic inRESET,
	input logic access_valid,
	input channel_id_t access_channel,
	input access_addr_t access_addr,
	input logic flush,
	input logic rd_req,
	input channel_id_t rd_sel,
	output logic rd_ack,
	output hit_count_t rd_data
);

	logic [`HM_CHANNELS-1:0] sample_valid;	// one-hot or zero.
	logic [`HM_CHANNELS-1:0] sample_hit;
	hit_count_t counts [`HM_CHANNELS];

	access_tag_probe i_access_tag_probe (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.access_valid(access_valid),
		.access_channel(access_channel),
		.access_addr(access_addr),
		.flush(flush),
		.sample_valid(sample_valid),
		.sample_hit(sample_hit)
	);

	// one window counter per cache channel.
	generate
		for (genvar ch = 0; ch < `HM_CHANNELS; ch++) begin : g_counter
			hit_window_counter i_hit_window_counter (
				.iCLOCK(iCLOCK),
				.inRESET(inRESET),
				.sample_valid(sample_valid[ch]),
				.sample_hit(sample_hit[ch]),
				.count(counts[ch])
			);
		end
	endgenerate

	hit_count_reader i_hit_count_reader (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.rd_req(rd_req),
		.rd_sel(rd_sel),
		.counts(counts),
		.rd_ack(rd_ack),
		.rd_data(rd_data)
	);

endmodule

//--- tests/hit_monitor_assert.sv
`timescale 1ns/1ns
`include "hit_monitor_settings.svh"

module hit_monitor_assert
	import hit_monitor_pkg::*;
(
	input logic iCLOCK,
	input logic inRESET,
	input logic rd_req,
	input logic rd_ack,
	input hit_count_t rd_data,
	input logic [`HM_CHANNELS-1:0] sample_valid
);

	int failures = 0;	// failed assertions so far.

	ack_rise: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		$rose(rd_ack) |-> $past(rd_req))
	else begin
		$error("rd_ack rose without rd_req high");
		failures++;
	end

	ack_fall: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		$fell(rd_ack) |-> !$past(rd_req))
	else begin
		$error("rd_ack fell while rd_req was still high");
		failures++;
	end

	// data is latched on the edge that raises ack.
	data_hold: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		(rd_ack && $past(rd_ack)) |-> $stable(rd_data))
	else begin
		$error("rd_data changed while rd_ack was high");
		failures++;
	end

	one_sample: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		$onehot0(sample_valid))
	else begin
		$error("more than one sample_valid bit set");
		failures++;
	end

endmodule

bind hit_monitor_top hit_monitor_assert i_hit_monitor_assert (
	.iCLOCK(iCLOCK),
	.inRESET(inRESET),
	.rd_req(rd_req),
	.rd_ack(rd_ack),
	.rd_data(rd_data),
	.sample_valid(sample_valid)
);

//--- tests/hit_monitor_checker.sv
`timescale 1ns/1ns
`include "hit_monitor_settings.svh"

module hit_monitor_checker
	import hit_monitor_pkg::*;
(
	input logic iCLOCK,
	input logic inRESET,
	input logic access_valid,
	input channel_id_t access_channel,
	input access_addr_t access_addr,
	input logic flush,
	input logic rd_req,
	input channel_id_t rd_sel,
	input logic rd_ack,
	input hit_count_t rd_data,
	output int error_count,
	output int check_count
);

	bit line_valid [`HM_CHANNELS][`HM_SETS];
	access_addr_t line_addr [`HM_CHANNELS][`HM_SETS];
	bit outcomes [`HM_CHANNELS][$];	// newest outcome at the front.
	channel_id_t read_sel;
	logic ack_seen = 1'b0;

	initial begin
		error_count = 0;
		check_count = 0;
	end

	function automatic hit_count_t expected_count(input channel_id_t ch);
		int hits;
		hits = 0;
		for (int i = 0; i < outcomes[ch].size(); i++) begin
			hits += outcomes[ch][i];
		end
		return hit_count_t'(hits);
	endfunction

	always @(posedge iCLOCK) begin : model_update
		int idx;
		bit hit;
		idx = access_addr % `HM_SETS;
		hit = !flush && line_valid[access_channel][idx]
			&& (line_addr[access_channel][idx] == access_addr);
		if (!inRESET) begin
			for (int c = 0; c < `HM_CHANNELS; c++) begin
				outcomes[c].delete();
				for (int s = 0; s < `HM_SETS; s++) begin
					line_valid[c][s] = 1'b0;
				end
			end
		end
		else begin
			if (access_valid) begin
				outcomes[access_channel].push_front(hit);
				if (outcomes[access_channel].size() > `HM_WINDOW_LEN) begin
					void'(outcomes[access_channel].pop_back());
				end
				if (!hit && !flush) begin
					line_valid[access_channel][idx] = 1'b1;	// miss allocates.
					line_addr[access_channel][idx] = access_addr;
				end
			end
			if (flush) begin
				for (int c = 0; c < `HM_CHANNELS; c++) begin
					for (int s = 0; s < `HM_SETS; s++) begin
						line_valid[c][s] = 1'b0;
					end
				end
			end
			if (rd_req && !rd_ack) begin
				read_sel = rd_sel;	// selection the reader takes.
			end
		end
	end

	// compare once per handshake, away from the active edge.
	always @(negedge iCLOCK) begin
		if (inRESET && rd_ack && !ack_seen) begin
			check_count++;
			if (rd_data !== expected_count(read_sel)) begin
				error_count++;
				$display("Error at %0t ns: channel %0d returned %0d hits, model expects %0d",
					$time, read_sel, rd_data, expected_count(read_sel));
			end
		end
		ack_seen = rd_ack;
	end

endmodule

//--- tests/hit_monitor_tb.sv
`timescale 1ns/1ns
`include "hit_monitor_settings.svh"

module hit_monitor_tb
	import hit_monitor_pkg::*;
();

	localparam int ACK_TIMEOUT = 20;

	logic iCLOCK;
	logic inRESET;
	logic access_valid;
	channel_id_t access_channel;
	access_addr_t access_addr;
	logic flush;
	logic rd_req;
	channel_id_t rd_sel;
	logic rd_ack;
	hit_count_t rd_data;
	int error_count;
	int check_count;
	int errors_before = 0;
	int checks_before = 0;
	int tests_passed = 0;
	int tests_failed = 0;

	hit_monitor_top i_hit_monitor_top (.*);

	hit_monitor_checker i_hit_monitor_checker (.*);

	initial begin
		iCLOCK = 1'b0;
		forever #4 iCLOCK = ~iCLOCK;
	end

	function automatic access_addr_t make_addr(input int tag, input int index);
		return {cache_tag_t'(tag), set_index_t'(index)};
	endfunction

	// every task starts just after a falling edge and ends on the next one.
	task automatic drive_access(input int ch, input access_addr_t addr);
		access_valid = 1'b1;
		access_channel = channel_id_t'(ch);
		access_addr = addr;
		flush = 1'b0;
		@(negedge iCLOCK);
	endtask

	task automatic idle_cycles(input int n);
		access_valid = 1'b0;
		flush = 1'b0;
		repeat (n) @(negedge iCLOCK);
	endtask

	task automatic pulse_flush(input logic with_access, input int ch, input access_addr_t addr);
		flush = 1'b1;
		access_valid = with_access;
		access_channel = channel_id_t'(ch);
		access_addr = addr;
		@(negedge iCLOCK);
		idle_cycles(0);
	endtask

	task automatic wait_ack(input logic level);
		int cycles;
		cycles = 0;
		while (rd_ack !== level && cycles < ACK_TIMEOUT) begin
			@(negedge iCLOCK);
			cycles++;
		end
		if (rd_ack !== level) begin
			$display("Timeout: rd_ack never went %s", level ? "high" : "low");
			$display("Checks failed");
			$finish;
		end
	endtask

	task automatic read_channel(input int ch, input int hold);
		rd_sel = channel_id_t'(ch);
		rd_req = 1'b1;
		wait_ack(1'b1);
		repeat (hold) @(negedge iCLOCK);	// a slow host keeps req high for a while.
		rd_req = 1'b0;
		wait_ack(1'b0);
	endtask

	task automatic report_test(input int num, input string name);
		int errs;
		int reads;
		errs = error_count + i_hit_monitor_top.i_hit_monitor_assert.failures - errors_before;
		reads = check_count - checks_before;
		if (errs == 0 && reads > 0) begin
			tests_passed++;
			$display("test %0d (%s) passed, %0d reads", num, name, reads);
		end
		else begin
			tests_failed++;
			$display("test %0d (%s) failed, %0d errors in %0d reads", num, name, errs, reads);
		end
		errors_before = errs + errors_before;
		checks_before = check_count;
	endtask

	initial begin
		void'($urandom(32'h404c));
		inRESET = 1'b0;
		access_valid = 1'b0;
		access_channel = '0;
		access_addr = '0;
		flush = 1'b0;
		rd_req = 1'b0;
		rd_sel = '0;
		repeat (2) @(posedge iCLOCK);
		@(negedge iCLOCK);
		inRESET = 1'b1;

		idle_cycles(8);
		for (int ch = 0; ch < `HM_CHANNELS; ch++) begin
			read_channel(ch, 0);
		end
		report_test(1, "reset counts");

		for (int pass = 0; pass < 3; pass++) begin
			for (int i = 0; i < 8; i++) begin
				drive_access(1, make_addr(8'h30 + i, i));
			end
		end
		idle_cycles(8);
		read_channel(1, 0);
		report_test(2, "cold misses then hits");

		for (int i = 0; i < 130; i++) begin
			drive_access(2, make_addr($urandom % 3, $urandom % 4));
		end
		idle_cycles(8);
		read_channel(2, 0);
		report_test(3, "window sliding");

		for (int i = 0; i < 200; i++) begin
			if ($urandom % 4 == 0) begin
				idle_cycles(1 + $urandom % 3);
			end
			drive_access($urandom % 4, make_addr($urandom % 2, $urandom % 4));
		end
		idle_cycles(8);
		for (int ch = 0; ch < `HM_CHANNELS; ch++) begin
			read_channel(ch, 0);
		end
		report_test(4, "channel independence");

		for (int pass = 0; pass < 2; pass++) begin
			for (int i = 0; i < 6; i++) begin
				drive_access(3, make_addr(8'h51, i));
			end
		end
		pulse_flush(1'b1, 3, make_addr(8'h51, 0));	// flush wins over this access.
		for (int i = 0; i < 6; i++) begin
			drive_access(3, make_addr(8'h51, i));
		end
		idle_cycles(8);
		read_channel(3, 0);
		read_channel(0, 0);
		report_test(5, "flush");

		for (int i = 0; i < 12; i++) begin
			idle_cycles($urandom % 5);	// zero gives back-to-back reads.
			read_channel($urandom % 4, $urandom % 4);
		end
		report_test(6, "handshake gaps");

		$display("%0d tests passed, %0d tests failed, %0d reads checked",
			tests_passed, tests_failed, check_count);
		if (tests_failed == 0) begin
			$display("All checks passed");
		end
		else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

//--- verilog.f
+incdir+rtl
rtl/hit_monitor_pkg.sv
rtl/access_tag_probe.sv
rtl/hit_window_counter.sv
rtl/hit_count_reader.sv
rtl/hit_monitor_top.sv
tests/hit_monitor_assert.sv
tests/hit_monitor_checker.sv
tests/hit_monitor_tb.sv
